//--- verilog/cpuConsts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath word width
`define DATA_WIDTH 64

// Fetched instruction width
`define INSTR_WIDTH 32

// Register file geometry
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// Hard-wired zero register, also the sink for instructions that write nothing
`define ZERO_REG 31

// Byte step between sequential instructions
`define PC_STEP 4

`endif

//--- verilog/isaPkg.sv
`include "cpuConsts.svh"

package isaPkg;

    typedef logic [`DATA_WIDTH-1:0] dataWordT;
    typedef logic [`INSTR_WIDTH-1:0] instrWordT;
    typedef logic [`REG_ADDR_WIDTH-1:0] regIdxT;

    // 11-bit opcode field, instr[31:21]
    // I-format opcodes are only 10 bits, so bit 0 is held at zero here
    typedef enum logic [10:0] {
        OpAdd  = 11'b001010_00000,
        OpAnd  = 11'b001010_00010,
        OpEor  = 11'b001010_00100,
        OpLsl  = 11'b001010_00110,
        OpLsr  = 11'b001010_00111,
        OpOrr  = 11'b001010_01000,
        OpSub  = 11'b001010_01001,
        OpAddi = 11'b100010_0000_0,
        OpAndi = 11'b100010_0010_0,
        OpEori = 11'b100010_0100_0,
        OpOrri = 11'b100010_0110_0,
        OpSubi = 11'b100010_0111_0,
        OpLdur = 11'b11010000000,
        OpStur = 11'b11010000001
    } opcodeT;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOrr,
        AluEor,
        AluLsl,
        AluLsr
    } aluOpT;

endpackage

//--- verilog/pipePkg.sv
package pipePkg;

    import isaPkg::*;

    // Data memory access carried down the pipe
    typedef enum logic [1:0] {
        MemNone,
        MemLoad,
        MemStore
    } memOpT;

    // MEM/WB result handed back to the register file
    typedef struct packed {
        logic     writeEn;
        regIdxT   idx;
        dataWordT data;
    } writebackT;

endpackage

//--- verilog/pipeIfs.sv
// ID/EX controls, registered in the decoder
interface decodeExecIf
    import isaPkg::*, pipePkg::*;
();
    aluOpT    aluOp;
    logic     useImm;
    dataWordT immValue;
    memOpT    memOp;
    regIdxT   destIdx;

    modport decoder (output aluOp, useImm, immValue, memOp, destIdx);
    modport execute (input aluOp, useImm, immValue, memOp, destIdx);
endinterface

// EX/MEM registers, owned by the execute stage
interface execMemIf
    import isaPkg::*, pipePkg::*;
();
    dataWordT aluResult;
    dataWordT storeData;
    memOpT    memOp;
    regIdxT   destIdx;

    modport execute (output aluResult, storeData, memOp, destIdx);
    modport memory (input aluResult, storeData, memOp, destIdx);
endinterface

//--- verilog/instructionDecoder.sv
`include "cpuConsts.svh"

module instructionDecoder
    import isaPkg::*, pipePkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instrWordT    ibus,
    output regIdxT       readIdxA,
    output regIdxT       readIdxB,
    decodeExecIf.decoder ctrl
);

    instrWordT instr;
    opcodeT    op;
    regIdxT    rn;
    regIdxT    rm;
    regIdxT    rd;
    dataWordT  immAlu;
    dataWordT  immShamt;
    dataWordT  immOffset;
    aluOpT     aluOpNext;
    logic      useImmNext;
    dataWordT  immNext;
    memOpT     memOpNext;
    logic      writesReg;
    regIdxT    destNext;

    // IF/ID, an all-zero word decodes as a no-op
    always_ff @(posedge clk)
    begin
        if (reset)
            instr <= '0;
        else
            instr <= ibus;
    end

    assign rn = instr[9:5];
    assign rm = instr[20:16];
    assign rd = instr[4:0];

    assign immAlu = dataWordT'(instr[21:10]);
    assign immShamt = dataWordT'(instr[15:10]);
    assign immOffset = {{(`DATA_WIDTH-9){instr[20]}}, instr[20:12]};

    // I-format only has a 10-bit opcode
    always_comb
    begin
        if (instr[31:26] == 6'b100010)
            op = opcodeT'({instr[31:22], 1'b0});
        else
            op = opcodeT'(instr[31:21]);
    end

    always_comb
    begin
        aluOpNext = AluAdd;
        useImmNext = 1'b0;
        immNext = immAlu;
        memOpNext = MemNone;
        writesReg = 1'b1;
        case (op)
            OpAdd: aluOpNext = AluAdd;
            OpSub: aluOpNext = AluSub;
            OpAnd: aluOpNext = AluAnd;
            OpOrr: aluOpNext = AluOrr;
            OpEor: aluOpNext = AluEor;
            OpLsl, OpLsr:
            begin
                aluOpNext = (op == OpLsl) ? AluLsl : AluLsr;
                useImmNext = 1'b1;
                immNext = immShamt;
            end
            OpAddi, OpSubi, OpAndi, OpOrri, OpEori:
            begin
                useImmNext = 1'b1;
                case (op)
                    OpSubi: aluOpNext = AluSub;
                    OpAndi: aluOpNext = AluAnd;
                    OpOrri: aluOpNext = AluOrr;
                    OpEori: aluOpNext = AluEor;
                    default: aluOpNext = AluAdd;
                endcase
            end
            OpLdur, OpStur:
            begin
                useImmNext = 1'b1;
                immNext = immOffset;
                memOpNext = (op == OpLdur) ? MemLoad : MemStore;
                writesReg = (op == OpLdur);
            end
            // Unknown encodings fall through as no-ops
            default: writesReg = 1'b0;
        endcase
    end

    // Stores read rt through the B port
    assign readIdxA = rn;
    assign readIdxB = (memOpNext == MemStore) ? rd : rm;

    assign destNext = writesReg ? rd : regIdxT'(`ZERO_REG);

    // ID/EX control
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl.aluOp <= AluAdd;
            ctrl.useImm <= 1'b0;
            ctrl.memOp <= MemNone;
            ctrl.destIdx <= regIdxT'(`ZERO_REG);
        end
        else
        begin
            ctrl.aluOp <= aluOpNext;
            ctrl.useImm <= useImmNext;
            ctrl.memOp <= memOpNext;
            ctrl.destIdx <= destNext;
        end
    end

    always_ff @(posedge clk)
    begin
        ctrl.immValue <= immNext;
    end

endmodule

//--- verilog/registerFile.sv
`include "cpuConsts.svh"

module registerFile
    import isaPkg::*, pipePkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  regIdxT    readIdxA,
    input  regIdxT    readIdxB,
    output dataWordT  readA,
    output dataWordT  readB,
    input  writebackT writeback
);

    dataWordT regs [`REG_COUNT];

    // Zero register first, then a same-cycle write, then the array
    function automatic dataWordT readReg(regIdxT idx);
        dataWordT value;
        if (idx == regIdxT'(`ZERO_REG))
            value = '0;
        else if (writeback.writeEn && (writeback.idx == idx))
            value = writeback.data;
        else
            value = regs[idx];
        return value;
    endfunction

    always_ff @(posedge clk)
    begin
        if (writeback.writeEn && (writeback.idx != regIdxT'(`ZERO_REG)))
            regs[writeback.idx] <= writeback.data;
    end

    always_comb
    begin
        readA = readReg(readIdxA);
        readB = readReg(readIdxB);
    end

    // MEM/WB must never present an enabled write with an X index
    assert property (@(posedge clk) disable iff (reset)
        writeback.writeEn |-> !$isunknown(writeback.idx));

endmodule

//--- verilog/executeStage.sv
`include "cpuConsts.svh"

module executeStage
    import isaPkg::*, pipePkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  dataWordT     readA,
    input  dataWordT     readB,
    decodeExecIf.execute ctrl,
    execMemIf.execute    mem
);

    dataWordT opA;
    dataWordT opB;
    dataWordT aluB;
    dataWordT aluOut;

    // ID/EX operands from the register file
    always_ff @(posedge clk)
    begin
        opA <= readA;
        opB <= readB;
    end

    assign aluB = ctrl.useImm ? ctrl.immValue : opB;

    always_comb
    begin
        case (ctrl.aluOp)
            AluAdd: aluOut = opA + aluB;
            AluSub: aluOut = opA - aluB;
            AluAnd: aluOut = opA & aluB;
            AluOrr: aluOut = opA | aluB;
            AluEor: aluOut = opA ^ aluB;
            // Shift amount is the low 6 bits only
            AluLsl: aluOut = opA << aluB[5:0];
            AluLsr: aluOut = opA >> aluB[5:0];
            default: aluOut = opA + aluB;
        endcase
    end

    // EX/MEM control
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem.memOp <= MemNone;
            mem.destIdx <= regIdxT'(`ZERO_REG);
        end
        else
        begin
            mem.memOp <= ctrl.memOp;
            mem.destIdx <= ctrl.destIdx;
        end
    end

    // Store data is the unmuxed B operand (rt)
    always_ff @(posedge clk)
    begin
        mem.aluResult <= aluOut;
        mem.storeData <= opB;
    end

    // A store leaving execute never targets a real register
    assert property (@(posedge clk) disable iff (reset)
        (mem.memOp == MemStore) |-> (mem.destIdx == regIdxT'(`ZERO_REG)));

endmodule

//--- verilog/memoryStage.sv
`include "cpuConsts.svh"

module memoryStage
    import isaPkg::*, pipePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    execMemIf.memory    mem,
    output dataWordT    dataAddr,
    output dataWordT    dataOut,
    output logic        dataRead,
    output logic        dataWrite,
    input  dataWordT    dataIn,
    output writebackT   writeback
);

    logic     wbEn;
    regIdxT   wbIdx;
    dataWordT wbData;

    // Data bus straight from EX/MEM
    assign dataAddr = mem.aluResult;
    assign dataOut = mem.storeData;
    assign dataRead = (mem.memOp == MemLoad);
    assign dataWrite = (mem.memOp == MemStore);

    // MEM/WB
    always_ff @(posedge clk)
    begin
        if (reset)
            wbEn <= 1'b0;
        else
            wbEn <= (mem.destIdx != regIdxT'(`ZERO_REG));
    end

    always_ff @(posedge clk)
    begin
        wbIdx <= mem.destIdx;
        wbData <= dataRead ? dataIn : mem.aluResult;
    end

    assign writeback = '{writeEn: wbEn, idx: wbIdx, data: wbData};

    assert property (@(posedge clk) disable iff (reset) !(dataRead && dataWrite));

endmodule

//--- verilog/cpuCore.sv
`include "cpuConsts.svh"

module cpuCore
    import isaPkg::*, pipePkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  instrWordT ibus,
    output dataWordT  iaddrbus,
    output dataWordT  dataAddr,
    output dataWordT  dataOut,
    input  dataWordT  dataIn,
    output logic      dataRead,
    output logic      dataWrite
);

    dataWordT  pc;
    regIdxT    readIdxA;
    regIdxT    readIdxB;
    dataWordT  readA;
    dataWordT  readB;
    writebackT writeback;

    decodeExecIf decodeExec ();
    execMemIf    execMem ();

    // No branches, so the PC only steps
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= '0;
        else
            pc <= pc + dataWordT'(`PC_STEP);
    end

    assign iaddrbus = pc;

    instructionDecoder decoder_inst (
        .clk      (clk),
        .reset    (reset),
        .ibus     (ibus),
        .readIdxA (readIdxA),
        .readIdxB (readIdxB),
        .ctrl     (decodeExec.decoder)
    );

    registerFile registerFile_inst (
        .clk       (clk),
        .reset     (reset),
        .readIdxA  (readIdxA),
        .readIdxB  (readIdxB),
        .readA     (readA),
        .readB     (readB),
        .writeback (writeback)
    );

    executeStage executeStage_inst (
        .clk   (clk),
        .reset (reset),
        .readA (readA),
        .readB (readB),
        .ctrl  (decodeExec.execute),
        .mem   (execMem.execute)
    );

    memoryStage memoryStage_inst (
        .clk       (clk),
        .reset     (reset),
        .mem       (execMem.memory),
        .dataAddr  (dataAddr),
        .dataOut   (dataOut),
        .dataRead  (dataRead),
        .dataWrite (dataWrite),
        .dataIn    (dataIn),
        .writeback (writeback)
    );

endmodule

//--- verification/cpuCoreTb.sv
module cpuCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    // R and D-format opcodes are 11 bits, I-format 10 bits
    localparam logic [10:0] OpcAdd = 11'b001010_00000;
    localparam logic [10:0] OpcSub = 11'b001010_01001;
    localparam logic [10:0] OpcAnd = 11'b001010_00010;
    localparam logic [10:0] OpcOrr = 11'b001010_01000;
    localparam logic [10:0] OpcEor = 11'b001010_00100;
    localparam logic [10:0] OpcLsl = 11'b001010_00110;
    localparam logic [10:0] OpcLsr = 11'b001010_00111;
    localparam logic [9:0] OpcAddi = 10'b100010_0000;
    localparam logic [9:0] OpcAndi = 10'b100010_0010;
    localparam logic [9:0] OpcOrri = 10'b100010_0110;
    localparam logic [9:0] OpcEori = 10'b100010_0100;
    localparam logic [9:0] OpcSubi = 10'b100010_0111;
    localparam logic [10:0] OpcLdur = 11'b11010000000;
    localparam logic [10:0] OpcStur = 11'b11010000001;
    localparam logic [10:0] OpcBogus = 11'h7FF;

    localparam logic [63:0] ValA = 64'h5A3;
    localparam logic [63:0] ValB = 64'h0F0;
    localparam logic [63:0] BaseAddr = 64'h100;
    localparam int MaxSlots = 200;

    typedef struct packed {
        logic [31:0] instr;
        logic        isLoad;
        logic        isStore;
        logic [63:0] addr;
        logic [63:0] data;
    } rowT;

    logic        clk;
    logic        reset;
    logic [31:0] ibus;
    logic [63:0] iaddrbus;
    logic [63:0] dataAddr;
    logic [63:0] dataOut;
    logic [63:0] dataIn;
    logic        dataRead;
    logic        dataWrite;

    rowT         progTable[$];
    logic [63:0] writeAddr[$];
    logic [63:0] writeData[$];
    int          storeCount;
    int          errors;
    int          checks;

    cpuCore cpuCore_inst (
        .clk       (clk),
        .reset     (reset),
        .ibus      (ibus),
        .iaddrbus  (iaddrbus),
        .dataAddr  (dataAddr),
        .dataOut   (dataOut),
        .dataIn    (dataIn),
        .dataRead  (dataRead),
        .dataWrite (dataWrite)
    );

    function automatic logic [31:0] encodeR(logic [10:0] opc, int rm, int shamt, int rn, int rd);
        return {opc, rm[4:0], shamt[5:0], rn[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] encodeI(logic [9:0] opc, int imm, int rn, int rd);
        return {opc, imm[11:0], rn[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] encodeD(logic [10:0] opc, longint off, int rn, int rt);
        return {opc, off[8:0], 2'b00, rn[4:0], rt[4:0]};
    endfunction

    task automatic addRow(logic [31:0] instr, logic isLoad, logic isStore,
                          logic [63:0] addr, logic [63:0] data);
        progTable.push_back('{instr, isLoad, isStore, addr, data});
        if (isStore)
            storeCount++;
    endtask

    task automatic addOp(logic [31:0] instr);
        addRow(instr, 1'b0, 1'b0, '0, '0);
    endtask

    // Every store uses X3 as its base
    task automatic addStore(int rt, longint offset, logic [63:0] data);
        addRow(encodeD(OpcStur, offset, 3, rt), 1'b0, 1'b1, BaseAddr + offset, data);
    endtask

    task automatic checkValue(string name, logic [63:0] got, logic [63:0] expected);
        checks++;
        assert (got === expected)
        else
        begin
            $display("[FAIL] %0t %s: expected %h, got %h", $time, name, expected, got);
            errors++;
        end
    endtask

    // Instruction memory by word index, data memory returns the inverted address
    task automatic driveInputs();
        int idx;
        idx = int'(iaddrbus[31:2]);
        if (idx < progTable.size())
            ibus = progTable[idx].instr;
        else
            ibus = '0;
        dataIn = ~dataAddr;
    endtask

    task automatic buildTable();
        // Operands and the store base, padded by two no-ops before first use
        addOp(encodeI(OpcAddi, int'(ValA), 31, 1));
        addOp(encodeI(OpcAddi, int'(ValB), 31, 2));
        addOp(encodeI(OpcAddi, int'(BaseAddr), 31, 3));
        addOp('0);
        addOp('0);
        addOp(encodeR(OpcAdd, 2, 0, 1, 4));
        addOp(encodeR(OpcSub, 2, 0, 1, 5));
        addOp(encodeR(OpcAnd, 2, 0, 1, 6));
        addOp(encodeR(OpcOrr, 2, 0, 1, 7));
        addOp(encodeR(OpcEor, 2, 0, 1, 8));
        addOp(encodeI(OpcAndi, 'h0FF, 1, 10));
        addOp(encodeI(OpcOrri, 'h80C, 1, 11));
        addOp(encodeI(OpcEori, 'hFFF, 1, 12));
        addOp(encodeI(OpcSubi, 'h5A4, 1, 13));
        addOp(encodeR(OpcLsl, 0, 52, 1, 14));
        addOp(encodeR(OpcLsr, 0, 4, 1, 15));
        // XZR as destination
        addOp(encodeI(OpcAddi, 'h123, 1, 31));
        addRow(encodeD(OpcLdur, -8, 3, 16), 1'b1, 1'b0, BaseAddr - 64'd8, '0);
        addStore(4, 0, ValA + ValB);
        addStore(5, 8, ValA - ValB);
        addStore(6, 16, ValA & ValB);
        addStore(7, 24, ValA | ValB);
        addStore(8, 32, ValA ^ ValB);
        addStore(10, 40, ValA & 64'h0FF);
        addStore(11, 48, ValA | 64'h80C);
        addStore(12, 56, ValA ^ 64'hFFF);
        addStore(13, 64, ValA - 64'h5A4);
        addStore(14, 72, ValA << 52);
        addStore(15, 80, ValA >> 4);
        addStore(16, 88, ~(BaseAddr - 64'd8));
        addStore(31, 96, '0);
        // Would overwrite X1 if it decoded as anything
        addOp(encodeR(OpcBogus, 2, 0, 2, 1));
        addOp('0);
        addOp('0);
        addStore(1, -16, ValA);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        int slot;
        int row;
        int storeIdx;
        logic expRead;
        logic expWrite;
        reset = 1'b1;
        ibus = '0;
        dataIn = '0;
        errors = 0;
        checks = 0;
        storeCount = 0;
        buildTable();

        // Five rising edges in reset
        repeat (5)
        begin
            @(negedge clk);
            driveInputs();
            checkValue("iaddrbus", iaddrbus, '0);
            checkValue("dataRead", 64'(dataRead), '0);
            checkValue("dataWrite", 64'(dataWrite), '0);
        end
        reset = 1'b0;

        // Memory stage holds the row fetched three slots earlier
        slot = 0;
        while ((writeAddr.size() < storeCount) && (slot < MaxSlots))
        begin
            @(negedge clk);
            slot++;
            driveInputs();
            checkValue("iaddrbus", iaddrbus, 64'(slot) * 64'd4);
            row = slot - 3;
            expRead = 1'b0;
            expWrite = 1'b0;
            if ((row >= 0) && (row < progTable.size()))
            begin
                expRead = progTable[row].isLoad;
                expWrite = progTable[row].isStore;
            end
            checkValue("dataRead", 64'(dataRead), 64'(expRead));
            checkValue("dataWrite", 64'(dataWrite), 64'(expWrite));
            // Load address is only on the bus during its memory cycle
            if (expRead)
                checkValue("dataAddr", dataAddr, progTable[row].addr);
            if (dataWrite)
            begin
                writeAddr.push_back(dataAddr);
                writeData.push_back(dataOut);
            end
        end
        if (writeAddr.size() < storeCount)
        begin
            $display("Timed out after %0d cycles with only %0d of %0d stores seen",
                     slot, writeAddr.size(), storeCount);
            errors++;
        end

        storeIdx = 0;
        foreach (progTable[i])
        begin
            if (progTable[i].isStore && (storeIdx < writeAddr.size()))
            begin
                checkValue("dataAddr", writeAddr[storeIdx], progTable[i].addr);
                checkValue("dataOut", writeData[storeIdx], progTable[i].data);
                storeIdx++;
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- cpuCore.f
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/pipeIfs.sv
verilog/instructionDecoder.sv
verilog/registerFile.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpuCore.sv
verification/cpuCoreTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps -j 0 \
    --top-module cpuCoreTb -f cpuCore.f -o cpuCoreSim

./obj_dir/cpuCoreSim | tee sim.log

if grep -q "TEST OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
